// ==== emmu_params.svh ====
`ifndef EMMU_PARAMS_SVH
`define EMMU_PARAMS_SVH

// ####################
// mesh geometry

`define EMMU_AW       32   // mesh address width
`define EMMU_PW       104  // full packet width, 3*aw + 8 control bits

// ####################
// translation table

`define EMMU_MAW      12   // table index width, 4096 entries
`define EMMU_IDX_LSB  20   // lowest dstaddr bit used as index
`define EMMU_BASE_W   44   // base width, top of a 64-bit address

// entry is stored as two config halves
`define EMMU_HALF_W   32

`endif

// ==== emmu_pkg.sv ====
`include "emmu_params.svh"

package emmu_pkg;

   // ####################
   // mesh packet

   // field order matches the emesh wire format, msb first
   typedef struct packed {
      logic [`EMMU_AW-1:0] srcaddr;  // return address
      logic [`EMMU_AW-1:0] data;     // payload or write data
      logic [`EMMU_AW-1:0] dstaddr;  // target, gets translated
      logic [4:0]          ctrlmode; // carried only
      logic [1:0]          datamode; // carried only
      logic                write;    // 1 = write, 0 = read
   } emesh_packet_t;

   // ####################
   // table entry

   // config view, the two 32-bit words the register port sees
   typedef struct packed {
      logic [`EMMU_HALF_W-1:0] hi; // addr bit 2 = 1
      logic [`EMMU_HALF_W-1:0] lo; // addr bit 2 = 0
   } mmu_halves_t;

   // translation view, base lives in the low 44 bits
   typedef struct packed {
      logic [2*`EMMU_HALF_W-`EMMU_BASE_W-1:0] rsvd; // ignored by lookup
      logic [`EMMU_BASE_W-1:0]                base; // upper part of 64-bit dst
   } mmu_xlat_t;

   // same stored word, decoded two ways
   typedef union packed {
      mmu_halves_t cfg;
      mmu_xlat_t   xlat;
   } mmu_entry_t;

   // ####################
   // ctrl -> table command

   typedef struct packed {
      logic                    wr_en; // store one half
      logic                    rd_en; // readback request
      logic                    half;  // 1 = hi word
      logic [`EMMU_MAW-1:0]    idx;   // entry index
      logic [`EMMU_HALF_W-1:0] wdata; // half-word to store
   } reg_cmd_t;

endpackage

// ==== emmu_ctrl.sv ====
`timescale 1ns/1ps
`include "emmu_params.svh"

module emmu_ctrl (
   input  logic                    rd_clk,
   input  logic                    nreset,
   // config side
   input  logic                    reg_access,
   input  emmu_pkg::emesh_packet_t reg_packet,
   // mesh side handshake
   input  logic                    emesh_access_in,
   input  logic                    emesh_wait_in,
   // readback word from table
   input  emmu_pkg::mmu_entry_t    rb_entry,
   output emmu_pkg::reg_cmd_t      reg_cmd,
   output logic                    lookup_en,
   output logic                    load_en,
   output logic                    emesh_access_out,
   output logic [`EMMU_HALF_W-1:0] reg_rdata,
   output logic                    reg_rvalid
);

   logic rb_half; // which half the pending readback asked for

   // ####################
   // config decode

   // address map: [14:3] entry, [2] half, [1:0] byte offset (ignored)
   always_comb begin
      reg_cmd.wr_en = reg_access & reg_packet.write;
      reg_cmd.rd_en = reg_access & ~reg_packet.write; // any read is a readback
      reg_cmd.half  = reg_packet.dstaddr[2];
      reg_cmd.idx   = reg_packet.dstaddr[`EMMU_MAW+2:3];
      reg_cmd.wdata = reg_packet.data[`EMMU_HALF_W-1:0];
   end

   // readback returns one cycle later, table read is registered
   always_ff @(posedge rd_clk) begin
      if (!nreset) begin
         reg_rvalid <= 1'b0;
         rb_half    <= 1'b0;
      end else begin
         reg_rvalid <= reg_cmd.rd_en;
         if (reg_cmd.rd_en) begin
            rb_half <= reg_cmd.half; // held until next request
         end
      end
   end

   // pick the half that was asked for
   assign reg_rdata = rb_half ? rb_entry.cfg.hi : rb_entry.cfg.lo;

   // ####################
   // mesh pipeline control

   // nothing moves while the sink pushes back
   assign lookup_en = emesh_access_in & ~emesh_wait_in; // only real packets hit the table
   assign load_en   = ~emesh_wait_in;                   // packet reg follows the valid bit

   // one stage, lines up with the table read
   always_ff @(posedge rd_clk) begin
      if (!nreset) begin
         emesh_access_out <= 1'b0;
      end else if (!emesh_wait_in) begin
         emesh_access_out <= emesh_access_in;
      end
   end

   // ####################
   // checks

   // output valid must freeze for the whole stall
   a_access_hold: assert property (
      @(posedge rd_clk) disable iff (!nreset)
      emesh_wait_in |=> $stable(emesh_access_out)
   );

   // a lone request gives exactly one rvalid pulse
   a_rvalid_pulse: assert property (
      @(posedge rd_clk) disable iff (!nreset)
      reg_cmd.rd_en ##1 !reg_cmd.rd_en |-> reg_rvalid ##1 !reg_rvalid
   );

endmodule

// ==== emmu_table.sv ====
`timescale 1ns/1ps
`include "emmu_params.svh"

module emmu_table (
   input  logic                 rd_clk,
   // config write / readback
   input  emmu_pkg::reg_cmd_t   reg_cmd,
   // mesh lookup
   input  logic                 lookup_en,
   input  logic [`EMMU_MAW-1:0] lookup_idx,
   output emmu_pkg::mmu_entry_t lookup_entry,
   output emmu_pkg::mmu_entry_t rb_entry
);

   localparam int DEPTH = 1 << `EMMU_MAW; // 4096 entries

   // 64-bit words, no reset, contents come from config writes
   emmu_pkg::mmu_entry_t mem [DEPTH];

   // ####################
   // write port

   // one half per write, the other half keeps its value
   always_ff @(posedge rd_clk) begin
      if (reg_cmd.wr_en) begin
         if (reg_cmd.half) begin
            mem[reg_cmd.idx].cfg.hi <= reg_cmd.wdata;
         end else begin
            mem[reg_cmd.idx].cfg.lo <= reg_cmd.wdata;
         end
      end
   end

   // ####################
   // lookup port

   // read-before-write, a write lands for lookups one cycle later
   // held on stall so entry and packet reg stay paired
   always_ff @(posedge rd_clk) begin
      if (lookup_en) begin
         lookup_entry <= mem[lookup_idx];
      end
   end

   // ####################
   // readback port

   // independent of the mesh side, never stalled
   always_ff @(posedge rd_clk) begin
      if (reg_cmd.rd_en) begin
         rb_entry <= mem[reg_cmd.idx];
      end
   end

   // ####################
   // checks

   // an x index would smear the write over unknown entries
   a_wr_idx_known: assert property (
      @(posedge rd_clk)
      reg_cmd.wr_en |-> !$isunknown(reg_cmd.idx)
   );

endmodule

// ==== emmu_remap.sv ====
`timescale 1ns/1ps
`include "emmu_params.svh"

module emmu_remap (
   input  logic                    rd_clk,
   input  logic                    load_en,
   input  logic                    mmu_en,
   input  emmu_pkg::emesh_packet_t emesh_packet_in,
   input  emmu_pkg::mmu_entry_t    lookup_entry,
   output emmu_pkg::emesh_packet_t emesh_packet_out,
   output logic [`EMMU_AW-1:0]     emesh_dstaddr_hi
);

   emmu_pkg::emesh_packet_t packet_q; // held packet, pairs with lookup_entry
   logic [2*`EMMU_AW-1:0]   dst_full; // translated 64-bit destination
   logic [`EMMU_BASE_W-1:0] base;     // entry seen through its base view

   // ####################
   // packet stage

   // payload only, validity lives in ctrl
   always_ff @(posedge rd_clk) begin
      if (load_en) begin
         packet_q <= emesh_packet_in;
      end
   end

   // ####################
   // address compose

   assign base = lookup_entry.xlat.base;

   // base replaces index bits, page offset passes through
   assign dst_full = {base, packet_q.dstaddr[`EMMU_IDX_LSB-1:0]};

   // mmu_en is a static config bit, used straight at the output
   always_comb begin
      emesh_packet_out = packet_q; // untouched fields ride along
      emesh_dstaddr_hi = '0;       // bypass: no upper address
      if (mmu_en) begin
         emesh_packet_out.dstaddr = dst_full[`EMMU_AW-1:0];
         emesh_dstaddr_hi         = dst_full[2*`EMMU_AW-1:`EMMU_AW]; // side port
      end
   end

endmodule

// ==== emmu_top.sv ====
`timescale 1ns/1ps
`include "emmu_params.svh"

module emmu_top (
   input  logic                    rd_clk,
   input  logic                    nreset,
   input  logic                    mmu_en,  // global translate enable
   // ####################
   // config port
   input  logic                    reg_access,
   input  emmu_pkg::emesh_packet_t reg_packet,
   output logic [`EMMU_HALF_W-1:0] reg_rdata,
   output logic                    reg_rvalid,
   // ####################
   // mesh port
   input  logic                    emesh_access_in,
   input  emmu_pkg::emesh_packet_t emesh_packet_in,
   input  logic                    emesh_wait_in, // stall from downstream
   output logic                    emesh_access_out,
   output emmu_pkg::emesh_packet_t emesh_packet_out,
   output logic [`EMMU_AW-1:0]     emesh_dstaddr_hi // upper 32 of translated dst
);

   emmu_pkg::reg_cmd_t   reg_cmd;      // ctrl -> table
   emmu_pkg::mmu_entry_t lookup_entry; // table -> remap
   emmu_pkg::mmu_entry_t rb_entry;     // table -> ctrl
   logic                 lookup_en;
   logic                 load_en;
   logic [`EMMU_MAW-1:0] lookup_idx;

   // top 12 address bits pick the entry
   assign lookup_idx = emesh_packet_in.dstaddr[`EMMU_AW-1:`EMMU_IDX_LSB];

   // control, decode + valid/stall
   emmu_ctrl u_ctrl (
      .rd_clk           (rd_clk),
      .nreset           (nreset),
      .reg_access       (reg_access),
      .reg_packet       (reg_packet),
      .emesh_access_in  (emesh_access_in),
      .emesh_wait_in    (emesh_wait_in),
      .rb_entry         (rb_entry),
      .reg_cmd          (reg_cmd),
      .lookup_en        (lookup_en),
      .load_en          (load_en),
      .emesh_access_out (emesh_access_out),
      .reg_rdata        (reg_rdata),
      .reg_rvalid       (reg_rvalid)
   );

   // translation table
   emmu_table u_table (
      .rd_clk       (rd_clk),
      .reg_cmd      (reg_cmd),
      .lookup_en    (lookup_en),
      .lookup_idx   (lookup_idx),
      .lookup_entry (lookup_entry),
      .rb_entry     (rb_entry)
   );

   // output datapath
   emmu_remap u_remap (
      .rd_clk           (rd_clk),
      .load_en          (load_en),
      .mmu_en           (mmu_en),
      .emesh_packet_in  (emesh_packet_in),
      .lookup_entry     (lookup_entry),
      .emesh_packet_out (emesh_packet_out),
      .emesh_dstaddr_hi (emesh_dstaddr_hi)
   );

endmodule

// ==== emmu_tb.sv ====
`timescale 1ns/1ps
`include "emmu_params.svh"

module emmu_tb;

   localparam int          DRV_DLY = 2;   // input skew after rising edge
   localparam int          POOL_N  = 16;  // entries used by translated lookups
   localparam logic [31:0] SEED    = 32'hba06_3cba;

   // one expected output beat
   typedef struct packed {
      emmu_pkg::emesh_packet_t pkt; // packet as it should leave
      logic [`EMMU_AW-1:0]     hi;  // expected side port
   } exp_item_t;

   logic                    rd_clk;
   logic                    nreset;
   logic                    mmu_en;
   logic                    reg_access;
   emmu_pkg::emesh_packet_t reg_packet;
   logic [`EMMU_HALF_W-1:0] reg_rdata;
   logic                    reg_rvalid;
   logic                    emesh_access_in;
   emmu_pkg::emesh_packet_t emesh_packet_in;
   logic                    emesh_wait_in;
   logic                    emesh_access_out;
   emmu_pkg::emesh_packet_t emesh_packet_out;
   logic [`EMMU_AW-1:0]     emesh_dstaddr_hi;

   // ####################
   // reference state

   logic [63:0]          model [1 << `EMMU_MAW]; // table words, hi:lo
   logic [`EMMU_MAW-1:0] pool [POOL_N];          // fully written entries
   exp_item_t            exp_q [$];              // scoreboard, in order
   exp_item_t            exp_head;               // front of queue, registered
   int                   exp_count = 0;
   logic                 rb_pend;                // readback due this cycle
   logic [31:0]          rb_exp;

   int err_mismatch = 0;
   int err_protocol = 0;
   int err_timeout  = 0;

   initial rd_clk = 1'b0;
   always #20 rd_clk = ~rd_clk; // 40 ns period

   emmu_top DUT (
      .rd_clk           (rd_clk),
      .nreset           (nreset),
      .mmu_en           (mmu_en),
      .reg_access       (reg_access),
      .reg_packet       (reg_packet),
      .reg_rdata        (reg_rdata),
      .reg_rvalid       (reg_rvalid),
      .emesh_access_in  (emesh_access_in),
      .emesh_packet_in  (emesh_packet_in),
      .emesh_wait_in    (emesh_wait_in),
      .emesh_access_out (emesh_access_out),
      .emesh_packet_out (emesh_packet_out),
      .emesh_dstaddr_hi (emesh_dstaddr_hi)
   );

   // translation rule: dst64 = {base44, addr[19:0]}, base = word[43:0]
   function automatic exp_item_t expect_out(input emmu_pkg::emesh_packet_t p);
      exp_item_t   it;
      logic [63:0] w;
      logic [43:0] base;
      it.pkt = p;
      it.hi  = '0; // bypass leaves the side port at zero
      if (mmu_en) begin
         w              = model[p.dstaddr[31:20]];
         base           = w[43:0];
         it.pkt.dstaddr = {base[11:0], p.dstaddr[19:0]};
         it.hi          = base[43:12];
      end
      return it;
   endfunction

   // config address: [14:3] entry, [2] half
   function automatic logic [31:0] model_half(input emmu_pkg::emesh_packet_t p);
      logic [63:0] w;
      w = model[p.dstaddr[14:3]];
      return p.dstaddr[2] ? w[63:32] : w[31:0];
   endfunction

   always @(posedge rd_clk) begin : model_update
      if (!nreset) begin
         exp_q.delete();
         rb_pend <= 1'b0;
         rb_exp  <= '0;
      end else begin
         if (emesh_access_out && !emesh_wait_in && exp_q.size() != 0) begin
            void'(exp_q.pop_front()); // sink took the head
         end
         if (emesh_access_in && !emesh_wait_in) begin
            exp_q.push_back(expect_out(emesh_packet_in)); // old table contents
         end
         rb_pend <= reg_access && !reg_packet.write;
         if (reg_access && !reg_packet.write) begin
            rb_exp <= model_half(reg_packet);
         end
         if (reg_access && reg_packet.write) begin
            if (reg_packet.dstaddr[2]) begin
               model[reg_packet.dstaddr[14:3]][63:32] = reg_packet.data;
            end else begin
               model[reg_packet.dstaddr[14:3]][31:0] = reg_packet.data;
            end
         end
      end
      exp_count <= exp_q.size();
      exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
   end

   // ####################
   // checks

   a_reset_low: assert property (@(posedge rd_clk)
      !nreset |=> !emesh_access_out && !reg_rvalid)
      else begin
         err_mismatch++;
         $display("mismatch at %0t: outputs not low during reset", $time);
      end

   a_out_data: assert property (@(posedge rd_clk) disable iff (!nreset)
      emesh_access_out && exp_count != 0 |->
         emesh_packet_out == exp_head.pkt && emesh_dstaddr_hi == exp_head.hi)
      else begin
         err_mismatch++;
         $display("mismatch at %0t: got %h/%h expected %h/%h", $time,
                  emesh_packet_out, emesh_dstaddr_hi, exp_head.pkt, exp_head.hi);
      end

   a_no_extra: assert property (@(posedge rd_clk) disable iff (!nreset)
      emesh_access_out |-> exp_count != 0)
      else begin
         err_protocol++;
         $display("output valid at %0t with no packet expected", $time);
      end

   a_no_loss: assert property (@(posedge rd_clk) disable iff (!nreset)
      !emesh_access_out |-> exp_count == 0)
      else begin
         err_protocol++;
         $display("expected packet never appeared on the output at %0t", $time);
      end

   a_latency: assert property (@(posedge rd_clk) disable iff (!nreset)
      emesh_access_in && !emesh_wait_in |=> emesh_access_out)
      else begin
         err_protocol++;
         $display("accepted packet missing one cycle later at %0t", $time);
      end

   a_hold: assert property (@(posedge rd_clk) disable iff (!nreset)
      emesh_wait_in && emesh_access_out |=>
         emesh_access_out && $stable(emesh_packet_out) && $stable(emesh_dstaddr_hi))
      else begin
         err_protocol++;
         $display("mesh output changed during wait at %0t", $time);
      end

   a_rvalid: assert property (@(posedge rd_clk) disable iff (!nreset)
      reg_rvalid == rb_pend)
      else begin
         err_protocol++;
         $display("readback valid at wrong cycle at %0t", $time);
      end

   a_rdata: assert property (@(posedge rd_clk) disable iff (!nreset)
      reg_rvalid |-> reg_rdata == rb_exp)
      else begin
         err_mismatch++;
         $display("mismatch at %0t: rdata %h expected %h", $time, reg_rdata, rb_exp);
      end

   // ####################
   // stimulus helpers

   task automatic step();
      @(posedge rd_clk);
      #DRV_DLY;
   endtask

   function automatic emmu_pkg::emesh_packet_t rand_packet(input bit from_pool);
      emmu_pkg::emesh_packet_t p;
      logic [31:0]             r;
      p.srcaddr = $urandom();
      p.data    = $urandom();
      p.dstaddr = $urandom();
      if (from_pool) begin
         p.dstaddr[31:20] = pool[$urandom_range(POOL_N-1)]; // only known entries
      end
      r          = $urandom();
      p.ctrlmode = r[4:0];
      p.datamode = r[6:5];
      p.write    = r[7];
      return p;
   endfunction

   // one config command, taken at the next edge
   task automatic cfg_cmd(input logic [11:0] idx, input logic half, input logic wr,
                          input logic [31:0] wdata);
      step();
      reg_access         = 1'b1;
      reg_packet         = rand_packet(1'b0);
      reg_packet.write   = wr;
      reg_packet.data    = wdata;
      reg_packet.dstaddr = {17'd0, idx, half, 2'b00};
   endtask

   task automatic cfg_read_check(input logic [11:0] idx, input logic half);
      int guard;
      cfg_cmd(idx, half, 1'b0, '0);
      step();
      reg_access = 1'b0;
      guard      = 0;
      while (!reg_rvalid && guard < 4) begin
         step();
         guard++;
      end
      if (!reg_rvalid) begin
         err_timeout++;
         $display("timeout waiting for readback of entry %0d", idx);
      end
   endtask

   // source holds its packet while wait is high
   task automatic send_stream(input int n, input int wait_pct, input bit from_pool);
      int sent;
      int guard;
      bit pend;
      sent  = 0;
      guard = 0;
      pend  = 0;
      step();
      while (sent < n && guard < n * 50) begin
         if (!pend) begin
            emesh_packet_in = rand_packet(from_pool);
            pend            = 1;
         end
         emesh_access_in = 1'b1;
         emesh_wait_in   = ($urandom_range(99) < wait_pct);
         step();
         guard++;
         if (!emesh_wait_in) begin
            sent++;
            pend = 0;
         end
      end
      if (sent < n) begin
         err_timeout++;
         $display("timeout sending stream, %0d of %0d accepted", sent, n);
      end
      emesh_access_in = 1'b0;
      emesh_wait_in   = 1'b0;
   endtask

   task automatic drain();
      int guard;
      guard = 0;
      while ((exp_count != 0 || emesh_access_out) && guard < 20) begin
         step();
         guard++;
      end
      if (exp_count != 0 || emesh_access_out) begin
         err_timeout++;
         $display("timeout waiting for the mesh pipeline to empty");
      end
   endtask

   // ####################
   // test sequence

   initial begin : stimulus
      logic [31:0] r;
      void'($urandom(SEED));
      nreset          = 1'b0;
      mmu_en          = 1'b0;
      reg_access      = 1'b0;
      reg_packet      = '0;
      emesh_access_in = 1'b0;
      emesh_packet_in = '0;
      emesh_wait_in   = 1'b0;
      for (int i = 0; i < POOL_N; i++) begin
         r       = $urandom();
         pool[i] = r[11:0];
      end
      repeat (8) @(posedge rd_clk);
      #DRV_DLY nreset = 1'b1;

      // both halves of every pool entry, then a random mix back to back
      for (int i = 0; i < POOL_N; i++) begin
         cfg_cmd(pool[i], 1'b0, 1'b1, $urandom());
         cfg_cmd(pool[i], 1'b1, 1'b1, $urandom());
      end
      for (int i = 0; i < 200; i++) begin
         r = $urandom();
         cfg_cmd(pool[r[7:4]], r[0], r[1], $urandom());
      end
      step();
      reg_access = 1'b0;
      cfg_read_check(pool[0], 1'b1);
      cfg_read_check(pool[1], 1'b0);

      // bypass, plain then with stalls
      send_stream(40, 0, 1'b0);
      drain();
      send_stream(40, 30, 1'b0);
      drain();

      // translated, full rate then heavy back-pressure
      mmu_en = 1'b1; // pipeline is empty here
      send_stream(60, 0, 1'b1);
      drain();
      send_stream(200, 35, 1'b1);
      drain();

      // write at edge n, lookup of same entry at edge n+1
      for (int k = 0; k < 8; k++) begin
         r = $urandom();
         cfg_cmd(pool[k], r[0], 1'b1, $urandom());
         step();
         reg_access                    = 1'b0;
         emesh_packet_in               = rand_packet(1'b1);
         emesh_packet_in.dstaddr[31:20] = pool[k];
         emesh_access_in               = 1'b1;
         step();
         emesh_access_in = 1'b0;
         drain();
      end

      step();
      $display("errors: mismatch %0d, protocol %0d, timeout %0d",
               err_mismatch, err_protocol, err_timeout);
      if (err_mismatch + err_protocol + err_timeout == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
emmu_pkg.sv
emmu_ctrl.sv
emmu_table.sv
emmu_remap.sv
emmu_top.sv
emmu_tb.sv

// ==== Makefile ====
# Verilator build and run for the emmu testbench

VERILATOR ?= verilator
TOP       ?= emmu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

PASS_MSG  := TEST PASS
SOURCES   := $(shell grep -v '^+' $(FILELIST)) emmu_params.svh
BIN       := $(BUILD_DIR)/V$(TOP)

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# status comes from the search for the pass line
test: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
